//--- rtl/buf_ctrl_pkg.sv
// Widths, depths and data types of the block buffer
// 32-bit input beats packed into 128-bit output words

package buf_ctrl_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int IN_W    = 32;   // Input beat
	localparam int OUT_W   = 128;  // Local-bus word
	localparam int LANES   = 4;    // Input beats per output word
	localparam int LANE_W  = 2;    // Lane select

	// ----------------------------------------
	// Buffer geometry
	// ----------------------------------------
	localparam int BLK_DEP = 64;   // Input words per block region
	localparam int BLK_NUM = 4;    // Regions in the ring
	localparam int BLK_W   = 2;    // Region number
	localparam int OFS_W   = 6;    // Input-word offset in a region
	localparam int DLEN_W  = 16;   // Reported length

	// Data words
	typedef logic [IN_W-1:0]  in_data_t;
	typedef logic [OUT_W-1:0] out_data_t;

	// Write address counts input words, read address output words
	typedef logic [BLK_W+OFS_W-1:0]        wadd_t;
	typedef logic [BLK_W+OFS_W-LANE_W-1:0] radd_t;

	// One extra bit so a full region of 64 fits
	typedef logic [OFS_W:0] blk_len_t;

	// Stored blocks, 0 to BLK_NUM
	typedef logic [BLK_W:0] blk_cnt_t;

	// Head length in output words, as seen by the reader
	typedef logic [DLEN_W-1:0] dlen_t;

endpackage

//--- rtl/buf_ctrl_if.sv
// Internal buses of the block buffer
// dbuf_if: RAM write and read ports
// blk_evt_if: block complete pulses, status and head length

`timescale 1ns/1ps

// ----------------------------------------
// RAM access
// ----------------------------------------
interface dbuf_if;
	logic                    wen;    // One input word
	buf_ctrl_pkg::wadd_t     wadd;   // {region, offset}
	buf_ctrl_pkg::in_data_t  wdata;
	logic                    ren;    // One output word
	buf_ctrl_pkg::radd_t     radd;
	buf_ctrl_pkg::out_data_t rdata;  // One cycle after ren

	// Write side
	modport wr (
		output wen, wadd, wdata
	);

	// Read side
	modport rd (
		output ren, radd,
		input  rdata
	);

	modport ram (
		input  wen, wadd, wdata, ren, radd,
		output rdata
	);
endinterface

// ----------------------------------------
// Block events and status
// ----------------------------------------
interface blk_evt_if;
	logic                   sof;        // Clear everything
	logic                   wcmp;       // Last word of a block written
	buf_ctrl_pkg::blk_len_t wlen;       // Input words, valid with wcmp
	logic                   rcmp;       // ren of the last word of a block
	logic                   rhold;      // Status hold after rlast
	logic                   not_full;
	logic                   not_empty;
	buf_ctrl_pkg::dlen_t    rd_len;     // Head length, output words
	buf_ctrl_pkg::blk_cnt_t blk_cnt;    // Blocks stored

	modport wr (
		output sof, wcmp, wlen,
		input  not_full
	);

	modport rd (
		input  sof, rd_len, blk_cnt,
		output rcmp, rhold
	);

	modport queue (
		input  sof, wcmp, wlen, rcmp, rhold,
		output not_full, not_empty, rd_len, blk_cnt
	);
endinterface

//--- rtl/blk_write_ctrl.sv
// Input stage of the block buffer
// Beat register, write address ring and block length

`timescale 1ns/1ps

module blk_write_ctrl (
	input  logic                   CLK_O,
	input  logic                   RST,
	input  logic                   tuser,   // SOF pulse
	input  logic                   tvalid,
	input  logic                   tlast,
	input  buf_ctrl_pkg::in_data_t tdata,
	output logic                   tready,
	dbuf_if.wr                     ram,
	blk_evt_if.wr                  evt
);

	logic                                accept;     // Beat taken this edge
	logic                                beat_vld;   // Registered beat waiting for RAM
	logic                                beat_last;
	buf_ctrl_pkg::in_data_t              beat_data;
	logic [buf_ctrl_pkg::BLK_W-1:0]      blk;        // Current region
	logic [buf_ctrl_pkg::OFS_W-1:0]      ofs;        // Next word in region

	// Room left and no last beat still in flight
	assign tready = evt.not_full;
	assign accept = tvalid & tready;

	// ----------------------------------------
	// Beat register
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			beat_vld  <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			beat_vld  <= accept;
			beat_last <= accept & tlast;  // Marks the pending last beat
		end
	end

	always_ff @(posedge CLK_O) begin
		if (accept) begin
			beat_data <= tdata;
		end
	end

	// ----------------------------------------
	// Write address ring
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			blk <= '0;
			ofs <= '0;
		end else if (tuser) begin  // SOF restarts at region 0
			blk <= '0;
			ofs <= '0;
		end else if (evt.wcmp) begin
			blk <= blk + 1'b1;  // Next region, wraps after the last one
			ofs <= '0;
		end else if (ram.wen) begin
			ofs <= ofs + 1'b1;
		end
	end

	assign ram.wen   = beat_vld;
	assign ram.wadd  = {blk, ofs};
	assign ram.wdata = beat_data;

	// Block events
	assign evt.sof  = tuser;
	assign evt.wcmp = beat_vld & beat_last;
	assign evt.wlen = {1'b0, ofs} + 1'b1;  // Offset of last word plus one

	// Blocked status only lets the pending last beat through
	a_no_write_when_full: assert property (@(posedge CLK_O) disable iff (RST)
		ram.wen && !evt.not_full |-> evt.wcmp);

endmodule

//--- rtl/blk_dbuf_ram.sv
// Block buffer RAM
// 32-bit lane writes, 128-bit registered reads

`timescale 1ns/1ps

module blk_dbuf_ram (
	input  logic CLK_O,
	dbuf_if.ram  ram
);

	// Lane j of word k holds input word 4k+j, lane 0 in the low bits
	logic [buf_ctrl_pkg::LANES-1:0][buf_ctrl_pkg::IN_W-1:0]
		mem [buf_ctrl_pkg::BLK_NUM*buf_ctrl_pkg::BLK_DEP/buf_ctrl_pkg::LANES];

	logic [$bits(buf_ctrl_pkg::radd_t)-1:0] wr_word;  // Output word being filled
	logic [buf_ctrl_pkg::LANE_W-1:0]        wr_lane;

	// Split input-word address into word and lane
	assign wr_word = ram.wadd[$bits(buf_ctrl_pkg::wadd_t)-1:buf_ctrl_pkg::LANE_W];
	assign wr_lane = ram.wadd[buf_ctrl_pkg::LANE_W-1:0];

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	always_ff @(posedge CLK_O) begin
		if (ram.wen) begin
			mem[wr_word][wr_lane] <= ram.wdata;
		end
	end

	// ----------------------------------------
	// Read port
	// ----------------------------------------
	// Data one cycle after ren, held otherwise
	always_ff @(posedge CLK_O) begin
		if (ram.ren) begin
			ram.rdata <= mem[ram.radd];
		end
	end

endmodule

//--- rtl/blk_len_queue.sv
// Block counter and queue of block lengths
// Not-full and not-empty status, head length in output words

`timescale 1ns/1ps

module blk_len_queue (
	input  logic     CLK_O,
	input  logic     RST,
	blk_evt_if.queue evt
);

	buf_ctrl_pkg::blk_cnt_t cnt;                              // Blocks stored
	buf_ctrl_pkg::blk_cnt_t wr_idx;                           // Entry for a new length
	buf_ctrl_pkg::blk_len_t len_q [buf_ctrl_pkg::BLK_NUM];    // Head at entry 0
	logic                   push;
	logic                   pop;
	logic [buf_ctrl_pkg::OFS_W-buf_ctrl_pkg::LANE_W:0] head_words;  // Whole output words
	logic                   head_part;                        // Partial last word

	assign push = evt.wcmp;
	assign pop  = evt.rcmp;

	// Pop shifts the queue down first
	assign wr_idx = pop ? cnt - 1'b1 : cnt;

	// ----------------------------------------
	// Block counter
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			cnt <= '0;
		end else if (evt.sof) begin
			cnt <= '0;
		end else if (push && !pop) begin
			cnt <= cnt + 1'b1;
		end else if (!push && pop) begin
			cnt <= cnt - 1'b1;
		end
		// Both at once leave it as is
	end

	// ----------------------------------------
	// Length queue
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			for (int i = 0; i < buf_ctrl_pkg::BLK_NUM; i++) begin
				len_q[i] <= '0;
			end
		end else if (evt.sof) begin
			for (int i = 0; i < buf_ctrl_pkg::BLK_NUM; i++) begin
				len_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < buf_ctrl_pkg::BLK_NUM - 1; i++) begin
				if (push && wr_idx == buf_ctrl_pkg::blk_cnt_t'(i)) begin
					len_q[i] <= evt.wlen;
				end else if (pop) begin
					len_q[i] <= len_q[i+1];
				end
			end
			// Tail entry has nothing behind it
			if (push && wr_idx == buf_ctrl_pkg::blk_cnt_t'(buf_ctrl_pkg::BLK_NUM - 1)) begin
				len_q[buf_ctrl_pkg::BLK_NUM-1] <= evt.wlen;
			end else if (pop) begin
				len_q[buf_ctrl_pkg::BLK_NUM-1] <= '0;
			end
		end
	end

	// Head length divided by four, rounded up
	assign head_words = len_q[0][buf_ctrl_pkg::OFS_W:buf_ctrl_pkg::LANE_W];
	assign head_part  = |len_q[0][buf_ctrl_pkg::LANE_W-1:0];
	assign evt.rd_len = buf_ctrl_pkg::dlen_t'(head_words) + buf_ctrl_pkg::dlen_t'(head_part);

	// ----------------------------------------
	// Status
	// ----------------------------------------
	// A block being written counts as taken
	assign evt.not_full  = (cnt < buf_ctrl_pkg::blk_cnt_t'(buf_ctrl_pkg::BLK_NUM)) && !evt.wcmp;
	assign evt.not_empty = (cnt != '0) && !evt.rhold;  // Low around rlast
	assign evt.blk_cnt   = cnt;

	a_cnt_max: assert property (@(posedge CLK_O) disable iff (RST)
		cnt <= buf_ctrl_pkg::blk_cnt_t'(buf_ctrl_pkg::BLK_NUM));

	// Reader finishing a block that was never stored
	a_cnt_min: assert property (@(posedge CLK_O) disable iff (RST)
		pop && !push && !evt.sof |-> cnt != '0);

endmodule

//--- rtl/blk_read_ctrl.sv
// Local-bus read side of the block buffer
// Read address ring, rvalid, rlast and status hold

`timescale 1ns/1ps

module blk_read_ctrl (
	input  logic   CLK_O,
	input  logic   RST,
	input  logic   ren,        // Local-bus read enable
	output logic   rvalid,
	output logic   rlast,
	output logic   tuser_out,  // SOF delayed one cycle
	dbuf_if.rd     ram,
	blk_evt_if.rd  evt
);

	logic [buf_ctrl_pkg::BLK_W-1:0]                    blk;  // Region being read
	logic [buf_ctrl_pkg::OFS_W-buf_ctrl_pkg::LANE_W-1:0] ofs;  // Output word in region
	buf_ctrl_pkg::dlen_t                               len_m1;
	logic                                              rcmp;
	logic                                              rlast_d;

	// Last word of the head block
	assign len_m1 = evt.rd_len - 1'b1;
	assign rcmp   = ren && (ofs == len_m1[buf_ctrl_pkg::OFS_W-buf_ctrl_pkg::LANE_W-1:0]);

	// ----------------------------------------
	// Read address ring
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			blk <= '0;
			ofs <= '0;
		end else if (evt.sof) begin
			blk <= '0;
			ofs <= '0;
		end else if (rcmp) begin
			blk <= blk + 1'b1;  // Wrap after last region
			ofs <= '0;
		end else if (ren) begin
			ofs <= ofs + 1'b1;
		end
	end

	assign ram.ren  = ren;
	assign ram.radd = {blk, ofs};

	// ----------------------------------------
	// Output strobes
	// ----------------------------------------
	always_ff @(posedge CLK_O or posedge RST) begin
		if (RST) begin
			rvalid    <= 1'b0;
			rlast     <= 1'b0;
			rlast_d   <= 1'b0;
			tuser_out <= 1'b0;
		end else begin
			rvalid    <= ren;      // Same cycle as RAM data
			rlast     <= rcmp;
			rlast_d   <= rlast;
			tuser_out <= evt.sof;
		end
	end

	assign evt.rcmp  = rcmp;
	assign evt.rhold = rlast | rlast_d;  // Reader then sees the new head length

	a_ren_needs_block: assert property (@(posedge CLK_O) disable iff (RST)
		ren |-> evt.blk_cnt != '0);

endmodule

//--- rtl/buf_ctrl_top.sv
// Block buffer top level
// Stream input to local-bus output, four block regions

`timescale 1ns/1ps

module buf_ctrl_top (
	input  logic                    CLK_O,
	input  logic                    RST,

	// Stream input
	input  logic                    i_axis_tuser,   // SOF pulse
	input  buf_ctrl_pkg::in_data_t  i_axis_tdata,
	input  logic                    i_axis_tvalid,
	input  logic                    i_axis_tlast,   // End of block
	output logic                    i_axis_tready,

	// Local bus
	output logic                    o_lbus_tuser,
	output logic                    o_lbus_status,  // Head block ready
	output buf_ctrl_pkg::dlen_t     o_lbus_dlen,    // Output words in head block
	input  logic                    o_lbus_ren,
	output buf_ctrl_pkg::out_data_t o_lbus_rdata,
	output logic                    o_lbus_rvalid,
	output logic                    o_lbus_rlast
);

	dbuf_if    dbuf ();
	blk_evt_if evt ();

	// ----------------------------------------
	// Blocks
	// ----------------------------------------
	blk_write_ctrl u_wr (
		.CLK_O  (CLK_O),
		.RST    (RST),
		.tuser  (i_axis_tuser),
		.tvalid (i_axis_tvalid),
		.tlast  (i_axis_tlast),
		.tdata  (i_axis_tdata),
		.tready (i_axis_tready),
		.ram    (dbuf.wr),
		.evt    (evt.wr)
	);

	blk_dbuf_ram u_ram (
		.CLK_O (CLK_O),
		.ram   (dbuf.ram)
	);

	blk_len_queue u_queue (
		.CLK_O (CLK_O),
		.RST   (RST),
		.evt   (evt.queue)
	);

	blk_read_ctrl u_rd (
		.CLK_O     (CLK_O),
		.RST       (RST),
		.ren       (o_lbus_ren),
		.rvalid    (o_lbus_rvalid),
		.rlast     (o_lbus_rlast),
		.tuser_out (o_lbus_tuser),
		.ram       (dbuf.rd),
		.evt       (evt.rd)
	);

	// Status and data straight from the queue and RAM
	assign o_lbus_status = evt.not_empty;
	assign o_lbus_dlen   = evt.rd_len;
	assign o_lbus_rdata  = dbuf.rdata;

endmodule

//--- bench/tb_buf_ctrl_checks.svh
// Compare tasks and error counters of the block buffer bench
// Included inside the bench module

`ifndef TB_BUF_CTRL_CHECKS_SVH
`define TB_BUF_CTRL_CHECKS_SVH

int    err_cnt  = 0;       // Failed checks, whole run
int    chk_cnt  = 0;
string cur_test = "none";  // Name shown on error lines

// Output word, only the lanes that carry block data
task automatic check_word(input string what, input buf_ctrl_pkg::out_data_t exp,
		input buf_ctrl_pkg::out_data_t act, input int lanes);
	buf_ctrl_pkg::out_data_t mask;
	mask = '0;
	for (int j = 0; j < lanes; j++) begin
		mask[j*buf_ctrl_pkg::IN_W +: buf_ctrl_pkg::IN_W] = '1;
	end
	chk_cnt++;
	if ((exp & mask) !== (act & mask)) begin
		err_cnt++;
		$display("error %s %s: expected %h actual %h", cur_test, what, exp & mask, act & mask);
	end
endtask

// Head length in output words
task automatic check_dlen(input string what, input buf_ctrl_pkg::dlen_t exp,
		input buf_ctrl_pkg::dlen_t act);
	chk_cnt++;
	if (exp !== act) begin
		err_cnt++;
		$display("error %s %s: expected %0d actual %0d", cur_test, what, exp, act);
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	chk_cnt++;
	if (exp !== act) begin
		err_cnt++;
		$display("error %s %s: expected %b actual %b", cur_test, what, exp, act);
	end
endtask

`endif

//--- bench/tb_buf_ctrl.sv
// Testbench for the block buffer
// Clock, reset, LFSR payload, stimulus table and test loop

`timescale 1ns/1ps

module tb_buf_ctrl;

	localparam int N_ROWS   = 5;
	localparam int MAX_BLK  = 5;     // Blocks per table row, 0 ends the list
	localparam int WAIT_LIM = 2000;  // Cycles allowed for any single wait

	logic                    CLK_O;
	logic                    RST;
	logic                    i_axis_tuser;
	buf_ctrl_pkg::in_data_t  i_axis_tdata;
	logic                    i_axis_tvalid;
	logic                    i_axis_tlast;
	logic                    i_axis_tready;
	logic                    o_lbus_tuser;
	logic                    o_lbus_status;
	buf_ctrl_pkg::dlen_t     o_lbus_dlen;
	logic                    o_lbus_ren;
	buf_ctrl_pkg::out_data_t o_lbus_rdata;
	logic                    o_lbus_rvalid;
	logic                    o_lbus_rlast;

	logic [31:0]            lfsr_state = 32'hecd6;
	buf_ctrl_pkg::in_data_t exp_words [$];  // Words written, oldest first
	int                     exp_lens [$];   // Block lengths in input words
	int                     test_cnt = 0;
	int                     tests_failed = 0;

	// ----------------------------------------
	// Stimulus table
	// ----------------------------------------
	string row_name [N_ROWS] = '{"mixed_lengths", "partial_words", "short_blocks",
		"fill_then_drain", "sof_clear"};
	int    row_len [N_ROWS][MAX_BLK] = '{
		'{8, 16, 64, 0, 0},
		'{5, 13, 0, 0, 0},
		'{1, 2, 3, 4, 0},
		'{16, 5, 64, 9, 13},  // Fifth block waits for a free region
		'{12, 64, 0, 0, 0}    // First block dropped by SOF
	};
	bit    row_fill [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	bit    row_sof  [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

	`include "tb_buf_ctrl_checks.svh"

	buf_ctrl_top dut (.*);

	initial begin
		CLK_O = 1'b0;
		forever #50 CLK_O = ~CLK_O;
	end

	// ----------------------------------------
	// Random source
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};  // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s in test %s", why, cur_test);
		$display("Simulation failed");
		$finish;
	endtask

	// Zero to two idle cycles
	task automatic idle_gap();
		logic [31:0] g;
		take_bits(2, g);
		if (g[1]) begin
			repeat (int'(g[0]) + 1) @(negedge CLK_O);
		end
	endtask

	// ----------------------------------------
	// Writer side, entered on a falling edge
	// ----------------------------------------
	task automatic put_beat(input buf_ctrl_pkg::in_data_t d, input logic last);
		int t;
		t = 0;
		i_axis_tdata  = d;
		i_axis_tlast  = last;
		i_axis_tvalid = 1'b1;
		while (!i_axis_tready) begin  // Taken on the next rising edge once high
			@(negedge CLK_O);
			t++;
			if (t > WAIT_LIM) abort_run("timeout waiting for tready");
		end
		@(negedge CLK_O);
		i_axis_tvalid = 1'b0;
		i_axis_tlast  = 1'b0;
	endtask

	task automatic write_block(input int n);
		logic [31:0] b;
		for (int i = 0; i < n; i++) begin
			idle_gap();
			take_bits(32, b);
			put_beat(b, i == n - 1);
			exp_words.push_back(b);
		end
		exp_lens.push_back(n);
	endtask

	// Beats with no last, thrown away by the following SOF
	task automatic write_partial(input int n);
		logic [31:0] b;
		for (int i = 0; i < n; i++) begin
			take_bits(32, b);
			put_beat(b, 1'b0);
		end
		repeat (2) @(negedge CLK_O);
	endtask

	task automatic pulse_sof();
		check_flag("status before sof", 1'b1, o_lbus_status);
		i_axis_tuser = 1'b1;
		@(negedge CLK_O);
		check_flag("tuser out", 1'b1, o_lbus_tuser);
		i_axis_tuser = 1'b0;
		exp_words.delete();
		exp_lens.delete();
		@(negedge CLK_O);
		check_flag("tuser out end", 1'b0, o_lbus_tuser);
		check_flag("status after sof", 1'b0, o_lbus_status);
		@(negedge CLK_O);
		check_flag("status after sof", 1'b0, o_lbus_status);
	endtask

	task automatic hold_full_check();
		repeat (16) begin
			@(negedge CLK_O);
			check_flag("tready while full", 1'b0, i_axis_tready);
		end
	endtask

	// ----------------------------------------
	// Reader side
	// ----------------------------------------
	task automatic read_block();
		int                      n_in;
		int                      words;
		int                      issued;
		int                      got;
		int                      lanes;
		int                      t;
		logic                    ren_now;
		logic [31:0]             g;
		buf_ctrl_pkg::out_data_t exp_w;
		t = 0;
		while (!o_lbus_status) begin
			@(negedge CLK_O);
			t++;
			if (t > WAIT_LIM) abort_run("timeout waiting for status");
		end
		n_in   = exp_lens.pop_front();
		words  = (n_in + 3) / 4;  // Rounded up to whole output words
		check_dlen("dlen", buf_ctrl_pkg::dlen_t'(words), o_lbus_dlen);
		issued = 0;
		got    = 0;
		t      = 0;
		while (got < words) begin
			ren_now = 1'b0;
			if (issued < words) begin
				take_bits(2, g);
				ren_now = (g[1:0] != 2'b00);  // One gap in four
			end
			o_lbus_ren = ren_now;
			if (ren_now) begin
				issued++;
			end
			@(negedge CLK_O);
			check_flag("rvalid", ren_now, o_lbus_rvalid);  // Exactly one cycle after ren
			if (ren_now) begin
				lanes = n_in - 4 * got;
				if (lanes > 4) lanes = 4;
				exp_w = '0;
				for (int j = 0; j < lanes; j++) begin
					exp_w[j*buf_ctrl_pkg::IN_W +: buf_ctrl_pkg::IN_W] = exp_words.pop_front();
				end
				check_word("rdata", exp_w, o_lbus_rdata, lanes);
				check_flag("rlast", got == words - 1, o_lbus_rlast);
				got++;
			end else begin
				check_flag("rlast", 1'b0, o_lbus_rlast);
			end
			t++;
			if (t > WAIT_LIM) abort_run("timeout reading a block");
		end
		o_lbus_ren = 1'b0;
		check_flag("status at rlast", 1'b0, o_lbus_status);
	endtask

	task automatic run_row(input int r);
		int nblk;
		nblk = 0;
		for (int i = 0; i < MAX_BLK; i++) begin
			if (row_len[r][i] != 0) nblk++;
		end
		for (int i = 0; i < nblk; i++) begin
			if (row_sof[r] && i == 1) begin
				write_partial(6);
				pulse_sof();
			end
			if (row_fill[r] && i == buf_ctrl_pkg::BLK_NUM) hold_full_check();
			if (row_fill[r] && i >= buf_ctrl_pkg::BLK_NUM) begin
				read_block();  // Frees one region
				check_flag("tready after read", 1'b1, i_axis_tready);
			end
			write_block(row_len[r][i]);
			if (!row_fill[r] && !(row_sof[r] && i == 0)) read_block();
		end
		while (exp_lens.size() > 0) begin
			read_block();
		end
	endtask

	task automatic report_test(input int base_err);
		test_cnt++;
		if (err_cnt == base_err) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, err_cnt - base_err);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int base_err;
		RST           = 1'b1;
		i_axis_tuser  = 1'b0;
		i_axis_tdata  = '0;
		i_axis_tvalid = 1'b0;
		i_axis_tlast  = 1'b0;
		o_lbus_ren    = 1'b0;
		repeat (8) @(negedge CLK_O);
		RST = 1'b0;
		@(negedge CLK_O);

		cur_test = "reset";
		base_err = err_cnt;
		check_flag("tready", 1'b1, i_axis_tready);
		check_flag("status", 1'b0, o_lbus_status);
		check_flag("rvalid", 1'b0, o_lbus_rvalid);
		check_flag("rlast", 1'b0, o_lbus_rlast);
		check_flag("tuser out", 1'b0, o_lbus_tuser);
		report_test(base_err);

		for (int r = 0; r < N_ROWS; r++) begin
			cur_test = row_name[r];
			base_err = err_cnt;
			run_row(r);
			report_test(base_err);
		end

		$display("tests %0d, tests failed %0d, checks %0d, errors %0d",
			test_cnt, tests_failed, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+bench
rtl/buf_ctrl_pkg.sv
rtl/buf_ctrl_if.sv
rtl/blk_write_ctrl.sv
rtl/blk_dbuf_ram.sv
rtl/blk_len_queue.sv
rtl/blk_read_ctrl.sv
rtl/buf_ctrl_top.sv
bench/tb_buf_ctrl.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_buf_ctrl
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(wildcard rtl/*.sv bench/*.sv bench/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
